// File: cache_subsys.f
logic/cache_pkg.sv
logic/axil_req_front.sv
logic/dm_cache_core.sv
logic/data_memory.sv
logic/axil_resp_back.sv
logic/cache_subsys_top.sv
sim/cache_subsys_tb.sv

// File: logic/axil_req_front.sv
`default_nettype none

module axil_req_front (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [cache_pkg::ADDR_W-1:0]   awaddr,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [cache_pkg::DATA_W-1:0]   wdata,
    input  logic [cache_pkg::STRB_W-1:0]   wstrb,
    input  logic                           wvalid,
    output logic                           wready,
    input  logic [cache_pkg::ADDR_W-1:0]   araddr,
    input  logic                           arvalid,
    output logic                           arready,
    output cache_pkg::cache_req_s          req,
    output logic                           req_valid,
    input  logic                           req_ready
);

    logic aw_full;
    logic w_full;
    logic ar_full;
    logic [cache_pkg::ADDR_W-1:0] aw_addr;
    logic [cache_pkg::ADDR_W-1:0] ar_addr;
    logic [cache_pkg::DATA_W-1:0] w_data;

    logic aw_take;
    logic w_take;
    logic ar_take;
    logic aw_full_n;
    logic w_full_n;
    logic ar_full_n;
    logic req_valid_n;
    cache_pkg::cache_req_s req_n;

    assign aw_take = awvalid & awready;
    assign w_take  = wvalid & wready;
    assign ar_take = arvalid & arready;

    always_comb begin
        aw_full_n   = aw_full | aw_take;
        w_full_n    = w_full | w_take;
        ar_full_n   = ar_full | ar_take;
        req_valid_n = req_valid & ~req_ready;   // held request still waiting
        req_n       = req;
        if (!req_valid_n && ar_full) begin      // reads go first
            req_n.write     = 1'b0;
            req_n.addr.word = ar_addr;
            req_n.wdata     = '0;
            ar_full_n       = 1'b0;
            req_valid_n     = 1'b1;
        end else if (!req_valid_n && aw_full && w_full) begin
            req_n.write     = 1'b1;
            req_n.addr.word = aw_addr;
            req_n.wdata     = w_data;
            aw_full_n       = 1'b0;
            w_full_n        = 1'b0;
            req_valid_n     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_full   <= 1'b0;
            w_full    <= 1'b0;
            ar_full   <= 1'b0;
            req_valid <= 1'b0;
            awready   <= 1'b0;
            wready    <= 1'b0;
            arready   <= 1'b0;
        end else begin
            aw_full   <= aw_full_n;
            w_full    <= w_full_n;
            ar_full   <= ar_full_n;
            req_valid <= req_valid_n;
            // no new beats while a request sits at the core
            awready   <= ~aw_full_n & ~req_valid_n;
            wready    <= ~w_full_n & ~req_valid_n;
            arready   <= ~ar_full_n & ~req_valid_n;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_take) aw_addr <= awaddr;
        if (w_take) w_data <= wdata;
        if (ar_take) ar_addr <= araddr;
        req <= req_n;
    end

    // partial writes are not supported
    a_wstrb_full: assert property (@(posedge clk) disable iff (rst)
        w_take |-> (wstrb == '1));

    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        (req_valid && !req_ready) |=> (req_valid && $stable(req)));

endmodule

`default_nettype wire

// File: logic/axil_resp_back.sv
`default_nettype none

module axil_resp_back (
    input  logic                           clk,
    input  logic                           rst,
    input  cache_pkg::cache_rsp_s          rsp,
    input  logic                           rsp_valid,
    output logic                           rsp_ready,
    output logic [cache_pkg::DATA_W-1:0]   rdata,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    output logic                           rhit,
    input  logic                           rready,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  logic                           bready
);

    logic rsp_take;

    // take a response only into an empty slot
    assign rsp_ready = rsp.write ? ~bvalid : ~rvalid;
    assign rsp_take  = rsp_valid & rsp_ready;

    assign rresp = cache_pkg::RESP_OKAY;
    assign bresp = cache_pkg::RESP_OKAY;

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            if (rvalid && rready) rvalid <= 1'b0;
            if (bvalid && bready) bvalid <= 1'b0;
            if (rsp_take) begin
                if (rsp.write) bvalid <= 1'b1;
                else rvalid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_take && !rsp.write) begin
            rdata <= rsp.rdata;
            rhit  <= rsp.hit;   // travels with rdata
        end
    end

endmodule

`default_nettype wire

// File: logic/cache_pkg.sv
`default_nettype none

package cache_pkg;

    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int STRB_W      = DATA_W / 8;   // one strobe per byte lane
    localparam int OFFSET_BITS = 2;            // byte offset inside a word
    localparam int SET_BITS    = 3;
    localparam int NUM_SETS    = 8;
    localparam int TAG_BITS    = 27;           // address above bit 4

    localparam int MEM_WORDS   = 256;
    localparam int MEM_IDX_W   = $clog2(MEM_WORDS);
    localparam int MEM_LATENCY = 3;            // cycles from request to done

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // address fields as the cache sees them
    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic [SET_BITS-1:0] set_idx;
        logic [OFFSET_BITS-1:0] offset;
    } addr_fields_s;

    // one address word, decoded either as a flat word or as cache fields
    typedef union packed {
        logic [ADDR_W-1:0] word;    // flat view, memory index
        addr_fields_s fields;       // tag/set/offset view
    } cache_addr_u;

    // bus request handed from the front to the core
    typedef struct packed {
        logic write;
        cache_addr_u addr;
        logic [DATA_W-1:0] wdata;
    } cache_req_s;

    // single access to the data memory
    typedef struct packed {
        logic write;
        cache_addr_u addr;          // byte address, low bits ignored
        logic [DATA_W-1:0] wdata;
    } mem_req_s;

    // completed access handed to the response side
    typedef struct packed {
        logic write;
        logic [DATA_W-1:0] rdata;   // zero for writes
        logic hit;
    } cache_rsp_s;

endpackage

`default_nettype wire

// File: logic/cache_subsys_top.sv
`default_nettype none

module cache_subsys_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [cache_pkg::ADDR_W-1:0]   awaddr,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [cache_pkg::DATA_W-1:0]   wdata,
    input  logic [cache_pkg::STRB_W-1:0]   wstrb,
    input  logic                           wvalid,
    output logic                           wready,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  logic                           bready,
    input  logic [cache_pkg::ADDR_W-1:0]   araddr,
    input  logic                           arvalid,
    output logic                           arready,
    output logic [cache_pkg::DATA_W-1:0]   rdata,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    input  logic                           rready,
    output logic                           rhit
);

    cache_pkg::cache_req_s req;
    logic req_valid;
    logic req_ready;

    cache_pkg::mem_req_s mem_req;
    logic mem_valid;
    logic mem_done;
    logic [cache_pkg::DATA_W-1:0] mem_rdata;

    cache_pkg::cache_rsp_s rsp;
    logic rsp_valid;
    logic rsp_ready;

    axil_req_front front_i (
        .clk       (clk),
        .rst       (rst),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready)
    );

    dm_cache_core core_i (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .mem_req   (mem_req),
        .mem_valid (mem_valid),
        .mem_done  (mem_done),
        .mem_rdata (mem_rdata),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    data_memory mem_i (
        .clk       (clk),
        .mem_req   (mem_req),
        .mem_valid (mem_valid),
        .mem_done  (mem_done),
        .mem_rdata (mem_rdata)
    );

    axil_resp_back back_i (
        .clk       (clk),
        .rst       (rst),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rhit      (rhit),
        .rready    (rready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready)
    );

endmodule

`default_nettype wire

// File: logic/data_memory.sv
`default_nettype none

module data_memory (
    input  logic                           clk,
    input  cache_pkg::mem_req_s            mem_req,
    input  logic                           mem_valid,
    output logic                           mem_done,
    output logic [cache_pkg::DATA_W-1:0]   mem_rdata
);

    logic [cache_pkg::DATA_W-1:0] mem_q [cache_pkg::MEM_WORDS];

    // one bit per cycle of latency, flushes to zero while idle
    logic [cache_pkg::MEM_LATENCY-1:0] pend;
    cache_pkg::mem_req_s op_q;
    logic [cache_pkg::MEM_IDX_W-1:0] op_idx;
    logic fire;

    // word index, upper address bits alias
    assign op_idx = op_q.addr.word[cache_pkg::MEM_IDX_W + cache_pkg::OFFSET_BITS - 1:
                                   cache_pkg::OFFSET_BITS];
    assign fire   = pend[cache_pkg::MEM_LATENCY-1];

    always_ff @(posedge clk) begin
        pend     <= {pend[cache_pkg::MEM_LATENCY-2:0], mem_valid};
        mem_done <= fire;
    end

    always_ff @(posedge clk) begin
        if (mem_valid) op_q <= mem_req;    // hold the access until it completes
    end

    always_ff @(posedge clk) begin
        if (fire && op_q.write) mem_q[op_idx] <= op_q.wdata;
    end

    always_ff @(posedge clk) begin
        if (fire && !op_q.write) mem_rdata <= mem_q[op_idx];
    end

endmodule

`default_nettype wire

// File: logic/dm_cache_core.sv
`default_nettype none

module dm_cache_core (
    input  logic                           clk,
    input  logic                           rst,
    input  cache_pkg::cache_req_s          req,
    input  logic                           req_valid,
    output logic                           req_ready,
    output cache_pkg::mem_req_s            mem_req,
    output logic                           mem_valid,
    input  logic                           mem_done,
    input  logic [cache_pkg::DATA_W-1:0]   mem_rdata,
    output cache_pkg::cache_rsp_s          rsp,
    output logic                           rsp_valid,
    input  logic                           rsp_ready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MEM_WAIT,
        ST_RESP
    } state_e;

    state_e state;

    logic [cache_pkg::NUM_SETS-1:0] valid_q;
    logic [cache_pkg::TAG_BITS-1:0] tag_q [cache_pkg::NUM_SETS];
    logic [cache_pkg::DATA_W-1:0]   data_q [cache_pkg::NUM_SETS];

    cache_pkg::cache_req_s cur;     // request being served
    logic hit_q;                    // hit status at acceptance

    logic [cache_pkg::SET_BITS-1:0] req_set;
    logic [cache_pkg::SET_BITS-1:0] cur_set;
    logic req_hit;
    logic accept;
    logic line_fill;
    logic line_upd;

    assign req_set   = req.addr.fields.set_idx;
    assign cur_set   = cur.addr.fields.set_idx;
    assign req_hit   = valid_q[req_set] && (tag_q[req_set] == req.addr.fields.tag);
    assign req_ready = (state == ST_IDLE);
    assign accept    = req_valid & req_ready;

    // line changes happen when memory answers
    assign line_fill = (state == ST_MEM_WAIT) & mem_done & ~cur.write;
    assign line_upd  = (state == ST_MEM_WAIT) & mem_done & cur.write & hit_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            valid_q   <= '0;
            mem_valid <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            mem_valid <= 1'b0;      // single-cycle pulse
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        if (!req.write && req_hit) begin
                            rsp_valid <= 1'b1;
                            state     <= ST_RESP;
                        end else begin
                            mem_valid <= 1'b1;
                            state     <= ST_MEM_WAIT;
                        end
                    end
                end
                ST_MEM_WAIT: begin
                    if (mem_done) begin
                        if (!cur.write) valid_q[cur_set] <= 1'b1;
                        rsp_valid <= 1'b1;
                        state     <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (rsp_ready) begin
                        rsp_valid <= 1'b0;
                        state     <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cur   <= req;
            hit_q <= req_hit;
            mem_req.write <= req.write;
            mem_req.addr  <= req.addr;
            mem_req.wdata <= req.wdata;
            // read hit answers straight from the array
            rsp.write <= req.write;
            rsp.rdata <= data_q[req_set];
            rsp.hit   <= req_hit;
        end else if ((state == ST_MEM_WAIT) && mem_done) begin
            rsp.write <= cur.write;
            rsp.rdata <= cur.write ? '0 : mem_rdata;
            rsp.hit   <= hit_q;
        end
    end

    always_ff @(posedge clk) begin
        if (line_fill) begin
            tag_q[cur_set]  <= cur.addr.fields.tag;
            data_q[cur_set] <= mem_rdata;
        end else if (line_upd) begin
            data_q[cur_set] <= cur.wdata;   // write-through refresh
        end
    end

    a_done_expected: assert property (@(posedge clk) disable iff (rst)
        mem_done |-> (state == ST_MEM_WAIT));

    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        !(rsp_valid && req_ready));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the cache subsystem testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cache_subsys_tb -f cache_subsys.f &&
./obj_dir/Vcache_subsys_tb | tee /dev/stderr | grep "TEST RESULT: PASS" > /dev/null &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: sim/cache_golden.mem
// op (0 read, 1 write, 2 reset, f end)  address  write data  expected rdata  expected rhit
// rdata and rhit columns are unused for writes, resets and the end marker
1 00000100 a1a10001 00000000 0
1 00000104 b2b20002 00000000 0
1 00000108 c3c30003 00000000 0
1 0000010c d4d40004 00000000 0
0 00000100 00000000 a1a10001 0
0 00000100 00000000 a1a10001 1
0 00000104 00000000 b2b20002 0
0 00000104 00000000 b2b20002 1
0 00000108 00000000 c3c30003 0
0 00000108 00000000 c3c30003 1
0 0000010c 00000000 d4d40004 0
0 0000010c 00000000 d4d40004 1
1 00000120 e5e50005 00000000 0
0 00000120 00000000 e5e50005 0
0 00000100 00000000 a1a10001 0
0 00000120 00000000 e5e50005 0
0 00000100 00000000 a1a10001 0
1 00000100 a1a10011 00000000 0
0 00000100 00000000 a1a10011 1
1 00000128 f6f60006 00000000 0
0 00000128 00000000 f6f60006 0
0 00000108 00000000 c3c30003 0
1 0000012c 9a9a0007 00000000 0
0 0000010c 00000000 d4d40004 1
0 0000012c 00000000 9a9a0007 0
2 00000000 00000000 00000000 0
0 0000010c 00000000 d4d40004 0
0 0000010c 00000000 d4d40004 1
0 00000100 00000000 a1a10011 0
f 00000000 00000000 00000000 0

// File: sim/cache_subsys_tb.sv
`default_nettype none

module cache_subsys_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_NS     = 100;
    localparam int RST_CYCLES = 8;
    localparam int MAX_TXN    = 64;
    localparam int FIELDS     = 5;            // op, addr, wdata, exp rdata, exp hit
    localparam logic [31:0] OP_READ  = 32'h0;
    localparam logic [31:0] OP_WRITE = 32'h1;
    localparam logic [31:0] OP_RESET = 32'h2;
    localparam logic [31:0] OP_END   = 32'hf;
    localparam logic [15:0] LFSR_SEED = 16'd24191;

    logic        clk;
    logic        rst;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        rhit;

    logic [31:0] gold [MAX_TXN*FIELDS];
    int n_txn;
    int n_rst;
    int limit_ns;

    cache_subsys_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_NS/2) clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1, shifting right
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) return (s >> 1) ^ 16'hB400;
        return s >> 1;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            abort_run("value check failed");
        end
    endtask

    task automatic read_txn(input int idx, input logic [31:0] addr,
                            input logic [31:0] exp_data, input logic [31:0] exp_hit);
        string name;
        name = $sformatf("txn %0d read %h", idx, addr);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        do @(posedge clk); while (!arready);     // AR transfer on this edge
        arvalid <= 1'b0;
        do @(posedge clk); while (!(rvalid && rready));
        check_value({name, " rdata"}, exp_data, rdata);
        check_value({name, " rhit"}, exp_hit, {31'b0, rhit});
        check_value({name, " rresp"}, 32'h0, {30'b0, rresp});
    endtask

    task automatic write_txn(input int idx, input logic [31:0] addr, input logic [31:0] data);
        bit aw_done;
        bit w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= '1;
        wvalid  <= 1'b1;
        while (!(aw_done && w_done)) begin     // AW and W may land on different edges
            @(posedge clk);
            if (!aw_done && awready) begin
                aw_done = 1'b1;
                awvalid <= 1'b0;
            end
            if (!w_done && wready) begin
                w_done = 1'b1;
                wvalid <= 1'b0;
            end
        end
        do @(posedge clk); while (!(bvalid && bready));
        check_value($sformatf("txn %0d write %h bresp", idx, addr), 32'h0, {30'b0, bresp});
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    endtask

    // random ready on R and B, one lfsr bit each per cycle
    initial begin : back_pressure
        logic [15:0] s;
        s = LFSR_SEED;
        forever begin
            @(posedge clk);
            rready <= s[0];
            s = lfsr_step(s);
            bready <= s[0];
            s = lfsr_step(s);
        end
    end

    initial begin : watchdog
        wait (limit_ns > 0);
        #(limit_ns);
        abort_run("transaction did not complete within the time limit");
    end

    initial begin : main
        int i;
        logic [31:0] op;
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        limit_ns = 0;
        $readmemh("sim/cache_golden.mem", gold);
        n_txn = 0;
        n_rst = 1;
        while (n_txn < MAX_TXN && gold[n_txn*FIELDS] !== OP_END) begin
            if (gold[n_txn*FIELDS] === OP_RESET) n_rst++;
            n_txn++;
        end
        if (n_txn == MAX_TXN) abort_run("golden file has no end marker");
        limit_ns = (n_txn * (cache_pkg::MEM_LATENCY + 20) + n_rst * RST_CYCLES) * CLK_NS;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (i = 0; i < n_txn; i++) begin
            op = gold[i*FIELDS];
            case (op)
                OP_READ:  read_txn(i, gold[i*FIELDS+1], gold[i*FIELDS+3], gold[i*FIELDS+4]);
                OP_WRITE: write_txn(i, gold[i*FIELDS+1], gold[i*FIELDS+2]);
                OP_RESET: pulse_reset();
                default:  abort_run($sformatf("unknown operation code %h in golden file", op));
            endcase
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
